// File: dispatch_pkg.sv
package dispatch_pkg;

    localparam int issue_width = 2;
    localparam int reg_count = 16;
    localparam int reg_addr_w = 4;
    localparam int data_w = 32;
    localparam int queue_depth = 8;

    // derived sizes
    localparam int q_ptr_w = $clog2(queue_depth);
    localparam int q_count_w = $clog2(queue_depth + 1);
    localparam int rf_read_ports = 2 * issue_width;

    // values match the opcode field of the instruction word
    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_xor  = 4'h4,
        op_addi = 4'h5,
        op_mul  = 4'h6
    } op_t;

    typedef logic [31:0] inst_word_t;

    typedef struct packed {
        logic                  valid;
        logic [data_w-1:0]     pc;
        op_t                   op;
        logic [reg_addr_w-1:0] rd;
        logic                  rd_we;
        logic [reg_addr_w-1:0] rs1;
        logic                  rs1_re;
        logic [reg_addr_w-1:0] rs2;
        logic                  rs2_re;
        logic [data_w-1:0]     imm;
    } decoded_op_t;

    typedef struct packed {
        logic                  valid;
        logic [data_w-1:0]     pc;
        op_t                   op;
        logic [reg_addr_w-1:0] rd;
        logic                  rd_we;
        logic [data_w-1:0]     src_a;
        logic [data_w-1:0]     src_b;
    } issued_op_t;

    // one pending register write
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [data_w-1:0]     data;
    } forward_t;

    typedef struct packed {
        logic                  valid;
        logic [data_w-1:0]     pc;
        logic [reg_addr_w-1:0] rd;
        logic                  rd_we;
        logic [data_w-1:0]     data;
    } retire_t;

endpackage

// File: decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  logic                                                 clk,
    input  logic                                                 reset_i,
    input  logic [dispatch_pkg::issue_width-1:0]                 fetch_valid_i,
    input  dispatch_pkg::inst_word_t [dispatch_pkg::issue_width-1:0] fetch_inst_i,
    input  logic [dispatch_pkg::data_w-1:0]                      fetch_pc_i,
    output logic                                                 fetch_stall_o,
    output dispatch_pkg::decoded_op_t [dispatch_pkg::issue_width-1:0] q_wr_o,
    input  logic [dispatch_pkg::q_count_w-1:0]                   q_room_i
);
    import dispatch_pkg::*;

    logic [1:0] pending_n;

    function automatic decoded_op_t decode_word(inst_word_t w, logic [data_w-1:0] pc);
        decoded_op_t d;
        d = '0;
        d.pc = pc;
        d.rd = w[27:24];
        d.rs1 = w[23:20];
        d.rs2 = w[19:16];
        d.imm = {{16{w[15]}}, w[15:0]};
        case (w[31:28])
            op_add, op_sub, op_and, op_xor, op_mul: begin
                d.op = op_t'(w[31:28]);
                d.rs1_re = 1'b1;
                d.rs2_re = 1'b1;
                d.rd_we = 1'b1;
            end
            op_addi: begin
                d.op = op_addi;
                d.rs1_re = 1'b1;
                d.rd_we = 1'b1;
            end
            // unknown opcodes still retire, but write nothing
            default: d.op = op_nop;
        endcase
        if (d.rd == '0) begin
            d.rd_we = 1'b0;
        end
        return d;
    endfunction

    // the pair still in flight to the queue counts against its room
    assign pending_n = 2'(q_wr_o[0].valid) + 2'(q_wr_o[1].valid);
    assign fetch_stall_o = q_room_i < (q_count_w'(pending_n) + q_count_w'(2));

    always_ff @(posedge clk) begin
        q_wr_o[0] <= decode_word(fetch_inst_i[0], fetch_pc_i);
        q_wr_o[1] <= decode_word(fetch_inst_i[1], fetch_pc_i + data_w'(4));
        for (int l = 0; l < issue_width; l++) begin
            q_wr_o[l].valid <= fetch_valid_i[l] && !fetch_stall_o;
        end
        if (reset_i) begin
            for (int l = 0; l < issue_width; l++) begin
                q_wr_o[l].valid <= 1'b0;
            end
        end
    end

    // fetch lanes arrive packed, lane 0 first
    lane_order_a: assert property (@(posedge clk) disable iff (reset_i)
        (fetch_valid_i[1] && !fetch_stall_o) |-> fetch_valid_i[0]);

endmodule

// File: inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
    input  logic                                                 clk,
    input  logic                                                 reset_i,
    input  dispatch_pkg::decoded_op_t [dispatch_pkg::issue_width-1:0] wr_i,
    output logic [dispatch_pkg::q_count_w-1:0]                   room_o,
    output dispatch_pkg::decoded_op_t [dispatch_pkg::issue_width-1:0] head_o,
    input  logic [1:0]                                           pop_i
);
    import dispatch_pkg::*;

    decoded_op_t mem [queue_depth];

    logic [q_ptr_w-1:0]   rd_ptr;
    logic [q_ptr_w-1:0]   wr_ptr;
    logic [q_count_w-1:0] count;
    logic [1:0]           push_n;
    logic [q_ptr_w-1:0]   wr_ptr_1;

    assign push_n = 2'(wr_i[0].valid) + 2'(wr_i[1].valid);

    // lane 1 lands right after lane 0 when both push
    assign wr_ptr_1 = wr_ptr + q_ptr_w'(wr_i[0].valid);

    always_ff @(posedge clk) begin
        if (wr_i[0].valid) begin
            mem[wr_ptr] <= wr_i[0];
        end
        if (wr_i[1].valid) begin
            mem[wr_ptr_1] <= wr_i[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            rd_ptr <= rd_ptr + q_ptr_w'(pop_i);
            wr_ptr <= wr_ptr + q_ptr_w'(push_n);
            count <= count + q_count_w'(push_n) - q_count_w'(pop_i);
        end
    end

    assign room_o = q_count_w'(queue_depth) - count;

    // two oldest entries, valid from the count
    always_comb begin
        head_o[0] = mem[rd_ptr];
        head_o[0].valid = (count != '0);
        head_o[1] = mem[rd_ptr + 1'b1];
        head_o[1].valid = (count > q_count_w'(1));
    end

    no_overflow_a: assert property (@(posedge clk) disable iff (reset_i)
        (int'(count) + int'(push_n) - int'(pop_i)) <= queue_depth);

    no_underflow_a: assert property (@(posedge clk) disable iff (reset_i)
        q_count_w'(pop_i) <= count);

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  logic [dispatch_pkg::rf_read_ports-1:0][dispatch_pkg::reg_addr_w-1:0] rd_addr_i,
    output logic [dispatch_pkg::rf_read_ports-1:0][dispatch_pkg::data_w-1:0]     rd_data_o,
    input  dispatch_pkg::forward_t [dispatch_pkg::issue_width-1:0]               wr_i
);
    import dispatch_pkg::*;

    logic [data_w-1:0] regs [reg_count];

    // lane 1 is younger, its write lands last
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int l = 0; l < issue_width; l++) begin
                if (wr_i[l].we && wr_i[l].addr != '0) begin
                    regs[wr_i[l].addr] <= wr_i[l].data;
                end
            end
        end
    end

    // r0 reads as zero
    always_comb begin
        for (int p = 0; p < rf_read_ports; p++) begin
            rd_data_o[p] = (rd_addr_i[p] == '0) ? '0 : regs[rd_addr_i[p]];
        end
    end

endmodule

// File: dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  logic                                                  clk,
    input  logic                                                  reset_i,
    input  dispatch_pkg::decoded_op_t [dispatch_pkg::issue_width-1:0] head_i,
    output logic [1:0]                                            pop_o,
    output logic [dispatch_pkg::rf_read_ports-1:0][dispatch_pkg::reg_addr_w-1:0] rf_addr_o,
    input  logic [dispatch_pkg::rf_read_ports-1:0][dispatch_pkg::data_w-1:0]     rf_data_i,
    input  dispatch_pkg::forward_t [dispatch_pkg::issue_width-1:0]  ex_fwd_i,
    input  logic [dispatch_pkg::issue_width-1:0]                    ex_late_i,
    input  dispatch_pkg::forward_t [dispatch_pkg::issue_width-1:0]  wb_fwd_i,
    output dispatch_pkg::issued_op_t [dispatch_pkg::issue_width-1:0] issue_o
);
    import dispatch_pkg::*;

    logic                                  lane1_dep;
    logic                                  pair_ok;
    logic [issue_width-1:0]                lane_issue;
    logic [issue_width-1:0]                lane_late;
    logic                                  stall;
    logic [rf_read_ports-1:0][data_w-1:0]  operand;
    issued_op_t [issue_width-1:0]          issue_d;

    // lane 1 must not read what lane 0 writes
    assign lane1_dep = head_i[0].rd_we &&
        ((head_i[1].rs1_re && head_i[1].rs1 == head_i[0].rd) ||
         (head_i[1].rs2_re && head_i[1].rs2 == head_i[0].rd));

    // mul always goes alone
    assign pair_ok = head_i[0].valid && head_i[1].valid && !lane1_dep &&
                     head_i[0].op != op_mul && head_i[1].op != op_mul;

    assign lane_issue = {pair_ok, head_i[0].valid};

    // late hazard: a mul result is not ready in execute
    always_comb begin
        for (int l = 0; l < issue_width; l++) begin
            lane_late[l] = 1'b0;
            for (int k = 0; k < issue_width; k++) begin
                if (lane_issue[l] && ex_late_i[k]) begin
                    if (head_i[l].rs1_re && head_i[l].rs1 == ex_fwd_i[k].addr) begin
                        lane_late[l] = 1'b1;
                    end
                    if (head_i[l].rs2_re && head_i[l].rs2 == ex_fwd_i[k].addr) begin
                        lane_late[l] = 1'b1;
                    end
                end
            end
        end
    end

    assign stall = |lane_late;
    assign pop_o = stall ? 2'd0 : 2'(lane_issue[0]) + 2'(lane_issue[1]);

    for (genvar l = 0; l < issue_width; l++) begin : g_rf_addr
        assign rf_addr_o[2*l] = head_i[l].rs1;
        assign rf_addr_o[2*l+1] = head_i[l].rs2;
    end

    // later loops override: ex beats wb beats regfile, lane 1 beats lane 0
    always_comb begin
        for (int p = 0; p < rf_read_ports; p++) begin
            operand[p] = rf_data_i[p];
            for (int k = 0; k < issue_width; k++) begin
                if (wb_fwd_i[k].we && wb_fwd_i[k].addr == rf_addr_o[p]) begin
                    operand[p] = wb_fwd_i[k].data;
                end
            end
            for (int k = 0; k < issue_width; k++) begin
                if (ex_fwd_i[k].we && ex_fwd_i[k].addr == rf_addr_o[p]) begin
                    operand[p] = ex_fwd_i[k].data;
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < issue_width; l++) begin
            issue_d[l].valid = lane_issue[l] && !stall;
            issue_d[l].pc = head_i[l].pc;
            issue_d[l].op = head_i[l].op;
            issue_d[l].rd = head_i[l].rd;
            issue_d[l].rd_we = head_i[l].rd_we;
            issue_d[l].src_a = head_i[l].rs1_re ? operand[2*l] : head_i[l].imm;
            issue_d[l].src_b = head_i[l].rs2_re ? operand[2*l+1] : head_i[l].imm;
        end
    end

    // a stall sends an empty pair
    always_ff @(posedge clk) begin
        issue_o <= issue_d;
        if (reset_i) begin
            for (int l = 0; l < issue_width; l++) begin
                issue_o[l].valid <= 1'b0;
            end
        end
    end

endmodule

// File: exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                                                   clk,
    input  logic                                                   reset_i,
    input  dispatch_pkg::issued_op_t [dispatch_pkg::issue_width-1:0] issue_i,
    output dispatch_pkg::forward_t [dispatch_pkg::issue_width-1:0]   ex_fwd_o,
    output logic [dispatch_pkg::issue_width-1:0]                     ex_late_o,
    output dispatch_pkg::forward_t [dispatch_pkg::issue_width-1:0]   wb_fwd_o,
    output dispatch_pkg::retire_t [dispatch_pkg::issue_width-1:0]    retire_o
);
    import dispatch_pkg::*;

    logic [issue_width-1:0]              is_mul;
    logic [issue_width-1:0][data_w-1:0]  alu_res;
    logic [issue_width-1:0][data_w-1:0]  ex_data;

    function automatic logic [data_w-1:0] alu(op_t op, logic [data_w-1:0] a,
                                              logic [data_w-1:0] b);
        case (op)
            op_add, op_addi: return a + b;
            op_sub: return a - b;
            op_and: return a & b;
            op_xor: return a ^ b;
            default: return '0;
        endcase
    endfunction

    always_comb begin
        for (int l = 0; l < issue_width; l++) begin
            is_mul[l] = issue_i[l].op == op_mul;
            alu_res[l] = alu(issue_i[l].op, issue_i[l].src_a, issue_i[l].src_b);
            // mul result is only usable from writeback
            ex_fwd_o[l].we = issue_i[l].valid && issue_i[l].rd_we && !is_mul[l];
            ex_fwd_o[l].addr = issue_i[l].rd;
            ex_fwd_o[l].data = alu_res[l];
            ex_late_o[l] = issue_i[l].valid && issue_i[l].rd_we && is_mul[l];
            // low half of the product
            ex_data[l] = is_mul[l] ? issue_i[l].src_a * issue_i[l].src_b : alu_res[l];
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < issue_width; l++) begin
            retire_o[l].valid <= issue_i[l].valid;
            retire_o[l].pc <= issue_i[l].pc;
            retire_o[l].rd <= issue_i[l].rd;
            retire_o[l].rd_we <= issue_i[l].rd_we;
            retire_o[l].data <= ex_data[l];
        end
        if (reset_i) begin
            for (int l = 0; l < issue_width; l++) begin
                retire_o[l].valid <= 1'b0;
            end
        end
    end

    // writeback register also feeds the regfile
    always_comb begin
        for (int l = 0; l < issue_width; l++) begin
            wb_fwd_o[l].we = retire_o[l].valid && retire_o[l].rd_we;
            wb_fwd_o[l].addr = retire_o[l].rd;
            wb_fwd_o[l].data = retire_o[l].data;
        end
    end

    // retirement stays in order from dispatch through writeback
    retire_order_a: assert property (@(posedge clk) disable iff (reset_i)
        retire_o[1].valid |-> retire_o[0].valid);

endmodule

// File: dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core (
    input  logic                                                 clk,
    input  logic                                                 reset_i,
    input  logic [dispatch_pkg::issue_width-1:0]                 fetch_valid_i,
    input  dispatch_pkg::inst_word_t [dispatch_pkg::issue_width-1:0] fetch_inst_i,
    input  logic [dispatch_pkg::data_w-1:0]                      fetch_pc_i,
    output logic                                                 fetch_stall_o,
    output dispatch_pkg::retire_t [dispatch_pkg::issue_width-1:0] retire_o
);
    import dispatch_pkg::*;

    decoded_op_t [issue_width-1:0]               q_wr;
    logic [q_count_w-1:0]                        q_room;
    decoded_op_t [issue_width-1:0]               head;
    logic [1:0]                                  pop;
    logic [rf_read_ports-1:0][reg_addr_w-1:0]    rf_addr;
    logic [rf_read_ports-1:0][data_w-1:0]        rf_data;
    issued_op_t [issue_width-1:0]                issue;
    forward_t [issue_width-1:0]                  ex_fwd;
    logic [issue_width-1:0]                      ex_late;
    forward_t [issue_width-1:0]                  wb_fwd;

    decode_unit decode_unit_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_valid_i(fetch_valid_i),
        .fetch_inst_i (fetch_inst_i),
        .fetch_pc_i   (fetch_pc_i),
        .fetch_stall_o(fetch_stall_o),
        .q_wr_o       (q_wr),
        .q_room_i     (q_room)
    );

    inst_queue inst_queue_i (
        .clk    (clk),
        .reset_i(reset_i),
        .wr_i   (q_wr),
        .room_o (q_room),
        .head_o (head),
        .pop_i  (pop)
    );

    regfile regfile_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .rd_addr_i(rf_addr),
        .rd_data_o(rf_data),
        .wr_i     (wb_fwd)
    );

    dispatch dispatch_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .head_i   (head),
        .pop_o    (pop),
        .rf_addr_o(rf_addr),
        .rf_data_i(rf_data),
        .ex_fwd_i (ex_fwd),
        .ex_late_i(ex_late),
        .wb_fwd_i (wb_fwd),
        .issue_o  (issue)
    );

    exec_stage exec_stage_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .issue_i  (issue),
        .ex_fwd_o (ex_fwd),
        .ex_late_o(ex_late),
        .wb_fwd_o (wb_fwd),
        .retire_o (retire_o)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real period_ns = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;
        end
    end

endmodule

// File: dual_issue_core_tb.sv
`timescale 1ns/1ps

module dual_issue_core_tb;
    import dispatch_pkg::*;

    localparam logic [data_w-1:0] base_pc = 32'h0000_1000;
    localparam int random_len = 240;
    localparam int drain_limit = 400;

    logic                         clk;
    logic                         reset_i;
    logic [issue_width-1:0]       fetch_valid_i;
    inst_word_t [issue_width-1:0] fetch_inst_i;
    logic [data_w-1:0]            fetch_pc_i;
    logic                         fetch_stall_o;
    retire_t [issue_width-1:0]    retire_o;

    inst_word_t        prog [$];
    retire_t           expected [$];
    logic [data_w-1:0] model_regs [reg_count];
    int                random_start = 0;
    int                retired = 0;
    int                mismatches = 0;
    int                other_errors = 0;
    int                stall_cycles = 0;
    logic              stall_seen = 1'b0;
    logic              prog_ready = 1'b0;

    tb_clock clock_gen (.clk(clk));

    dual_issue_core dual_issue_core_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_valid_i(fetch_valid_i),
        .fetch_inst_i (fetch_inst_i),
        .fetch_pc_i   (fetch_pc_i),
        .fetch_stall_o(fetch_stall_o),
        .retire_o     (retire_o)
    );

    function automatic inst_word_t encode(logic [3:0] op, logic [3:0] rd, logic [3:0] rs1,
                                          logic [3:0] rs2, logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    // one instruction in program order on model_regs
    function automatic retire_t model_step(inst_word_t w, logic [data_w-1:0] pc);
        retire_t           r;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] imm;
        r = '0;
        r.valid = 1'b1;
        r.pc = pc;
        r.rd = w[27:24];
        r.rd_we = (w[27:24] != 4'h0);
        a = model_regs[w[23:20]];
        b = model_regs[w[19:16]];
        imm = {{16{w[15]}}, w[15:0]};
        case (w[31:28])
            op_add:  r.data = a + b;
            op_sub:  r.data = a - b;
            op_and:  r.data = a & b;
            op_xor:  r.data = a ^ b;
            op_addi: r.data = a + imm;
            op_mul:  r.data = a * b;
            default: begin
                r.rd_we = 1'b0;
                r.data = '0;
            end
        endcase
        if (r.rd_we) begin
            model_regs[r.rd] = r.data;
        end
        return r;
    endfunction

    task automatic add_inst(logic [3:0] op, logic [3:0] rd, logic [3:0] rs1,
                            logic [3:0] rs2, logic [15:0] imm);
        prog.push_back(encode(op, rd, rs1, rs2, imm));
    endtask

    task automatic build_program();
        logic [3:0] op;
        int         pick;
        // independent ALU pairs
        add_inst(op_addi, 1, 0, 0, 16'h0123);
        add_inst(op_addi, 2, 0, 0, 16'hFFF0);
        add_inst(op_addi, 3, 0, 0, 16'h7FFF);
        add_inst(op_addi, 4, 0, 0, 16'h8001);
        add_inst(op_add, 5, 1, 2, 16'h0);
        add_inst(op_sub, 6, 3, 4, 16'h0);
        add_inst(op_and, 7, 1, 3, 16'h0);
        add_inst(op_xor, 8, 2, 4, 16'h0);
        add_inst(op_addi, 9, 3, 0, 16'h0011);
        add_inst(op_add, 10, 4, 1, 16'h0);
        // dependent chains within a pair and across pairs
        add_inst(op_add, 11, 1, 1, 16'h0);
        add_inst(op_add, 11, 11, 2, 16'h0);
        add_inst(op_sub, 12, 11, 3, 16'h0);
        add_inst(op_xor, 12, 12, 11, 16'h0);
        add_inst(op_and, 13, 12, 11, 16'h0);
        add_inst(op_addi, 13, 13, 0, 16'h0100);
        add_inst(op_addi, 1, 1, 0, 16'h0001);
        add_inst(op_addi, 2, 2, 0, 16'h0002);
        add_inst(op_add, 14, 13, 12, 16'h0);
        add_inst(op_add, 15, 1, 2, 16'h0);
        add_inst(op_sub, 15, 15, 14, 16'h0);
        add_inst(op_xor, 14, 15, 1, 16'h0);
        // mul with a reader right behind it
        add_inst(op_mul, 5, 3, 4, 16'h0);
        add_inst(op_add, 6, 5, 1, 16'h0);
        add_inst(op_mul, 7, 6, 6, 16'h0);
        add_inst(op_mul, 8, 7, 2, 16'h0);
        add_inst(op_sub, 9, 8, 7, 16'h0);
        add_inst(op_mul, 10, 1, 2, 16'h0);
        add_inst(op_addi, 11, 0, 0, 16'h0007);
        add_inst(op_xor, 12, 10, 11, 16'h0);
        add_inst(op_mul, 13, 9, 9, 16'h0);
        add_inst(op_mul, 13, 13, 13, 16'h0);
        // r0 writes and reads and unknown opcodes
        add_inst(op_add, 0, 1, 2, 16'h0);
        add_inst(op_add, 5, 0, 1, 16'h0);
        add_inst(op_addi, 0, 0, 0, 16'h0055);
        add_inst(op_sub, 6, 0, 0, 16'h0);
        add_inst(4'hA, 7, 1, 2, 16'h1234);
        add_inst(op_add, 7, 7, 0, 16'h0);
        add_inst(4'hF, 8, 8, 8, 16'hFFFF);
        add_inst(op_xor, 8, 0, 6, 16'h0);
        add_inst(op_mul, 0, 3, 4, 16'h0);
        add_inst(op_add, 9, 0, 3, 16'h0);
        random_start = prog.size();
        for (int i = 0; i < random_len; i++) begin
            pick = $urandom_range(0, 11);
            case (pick)
                0, 1:    op = op_add;
                2:       op = op_sub;
                3:       op = op_and;
                4:       op = op_xor;
                5, 6:    op = op_addi;
                7, 8, 9: op = op_mul;
                default: op = 4'($urandom_range(7, 15));
            endcase
            add_inst(op, 4'($urandom_range(0, 15)), 4'($urandom_range(0, 15)),
                     4'($urandom_range(0, 15)), 16'($urandom()));
        end
    endtask

    // words are held while fetch is stalled
    task automatic feed_program();
        int idx;
        int n_lanes;
        int gap_pct;
        idx = 0;
        n_lanes = 0;
        while (idx < prog.size()) begin
            @(posedge clk);
            if (n_lanes > 0 && !stall_seen) begin
                idx += n_lanes;
                n_lanes = 0;
            end
            if (n_lanes == 0) begin
                // gaps only in the random part
                gap_pct = (idx >= random_start) ? 15 : 0;
                if (idx < prog.size() && $urandom_range(0, 99) >= gap_pct) begin
                    n_lanes = 1;
                    if (idx + 1 < prog.size() &&
                        (idx < random_start || $urandom_range(0, 9) != 0)) begin
                        n_lanes = 2;
                    end
                    fetch_pc_i <= base_pc + 32'(4 * idx);
                    fetch_inst_i[0] <= prog[idx];
                    fetch_inst_i[1] <= (n_lanes == 2) ? prog[idx + 1] : '0;
                end
                fetch_valid_i <= {n_lanes == 2, n_lanes >= 1};
            end
        end
    endtask

    task automatic check_retire(retire_t got);
        retire_t exp;
        if (retired >= expected.size()) begin
            $display("unexpected retirement past the end of the program at pc %h", got.pc);
            other_errors++;
        end else begin
            exp = expected[retired];
            if (got.pc !== exp.pc) begin
                $display("MISMATCH retire_o.pc: expected %h actual %h", exp.pc, got.pc);
                mismatches++;
            end
            if (got.rd !== exp.rd) begin
                $display("MISMATCH retire_o.rd at pc %h: expected %h actual %h",
                         exp.pc, exp.rd, got.rd);
                mismatches++;
            end
            if (got.rd_we !== exp.rd_we) begin
                $display("MISMATCH retire_o.rd_we at pc %h: expected %h actual %h",
                         exp.pc, exp.rd_we, got.rd_we);
                mismatches++;
            end
            if (exp.rd_we && got.data !== exp.data) begin
                $display("MISMATCH retire_o.data at pc %h: expected %h actual %h",
                         exp.pc, exp.data, got.data);
                mismatches++;
            end
        end
        retired++;
    endtask

    always @(negedge clk) begin
        stall_seen = fetch_stall_o;
        if (!reset_i && fetch_stall_o) begin
            stall_cycles++;
        end
    end

    // lane 0 is older
    always @(negedge clk) begin
        if (!reset_i) begin
            for (int l = 0; l < issue_width; l++) begin
                if (retire_o[l].valid) begin
                    check_retire(retire_o[l]);
                end
            end
        end
    end

    initial begin
        wait (prog_ready);
        repeat (40 * prog.size() + 100) @(posedge clk);
        $display("timeout: only %0d of %0d instructions retired", retired, expected.size());
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int drain;
        void'($urandom(32'h222a));
        reset_i = 1'b1;
        fetch_valid_i = '0;
        fetch_inst_i = '0;
        fetch_pc_i = '0;
        build_program();
        for (int r = 0; r < reg_count; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < prog.size(); i++) begin
            expected.push_back(model_step(prog[i], base_pc + 32'(4 * i)));
        end
        prog_ready = 1'b1;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        feed_program();
        drain = 0;
        while (retired < expected.size() && drain < drain_limit) begin
            @(posedge clk);
            drain++;
        end
        // extra cycles to catch duplicate retirements
        repeat (8) @(posedge clk);
        if (retired < expected.size()) begin
            $display("missing retirements: %0d of %0d instructions retired",
                     retired, expected.size());
            other_errors++;
        end
        if (stall_cycles == 0) begin
            $display("fetch_stall_o never went high, the queue was never filled");
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: dual_issue_core.f
dispatch_pkg.sv
decode_unit.sv
inst_queue.sv
regfile.sv
dispatch.sv
exec_stage.sv
dual_issue_core.sv
tb_clock.sv
dual_issue_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dual-issue core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dual_issue_core_tb -Mdir obj_dir -f dual_issue_core.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vdual_issue_core_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" <<< "$output"; then
    exit 0
fi
exit 1
